/* Makefile */
# Verilator build, run and lint for the audio and host control block

VERILATOR ?= verilator
TOP       ?= tb_sys_audio_top
LINT_TOP  ?= sys_audio_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q '^Testbench passed$$'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hdl/sys_pkg.sv
hdl/hps_cmd_regs.sv
hdl/aud_mix_chan.sv
hdl/panel_io.sv
hdl/sys_audio_top.sv
testbench/tb_sys_audio_top.sv

/* hdl/aud_mix_chan.sv */
/*
  One audio mixer channel
  - glitch filter on the core sample
  - unsigned to signed conversion and host audio sum
  - stereo cross-mix with the other channel
  - attenuation, mute and 16-bit clamp
*/
`timescale 1ns/1ps
`default_nettype none

module aud_mix_chan
	import sys_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_resetd,
	input  wire audio_cfg_t i_cfg,
	input  wire sample_t    i_core,
	input  wire sample_t    i_linux,
	input  wire sample_t    i_pre_in,
	output sample_t         o_pre,
	output sample_t         o_sample
);

	sample_t      core_dly [GLITCH_DLY];
	sample_t      lin_dly  [GLITCH_DLY];
	sample_t      core_ok;
	wide_sample_t conv_q;
	wide_sample_t sum_q;
	wide_sample_t mix_q;
	wide_sample_t att_q;
	wide_sample_t conv_d;
	wide_sample_t pre_w;
	wide_sample_t mix_d;

	// Unsigned samples are halved so they fit next to a signed one
	assign conv_d = i_cfg.is_signed ? {core_ok[15], core_ok} : {2'b00, core_ok[15:1]};
	assign pre_w  = {i_pre_in[15], i_pre_in};
	assign o_pre  = sum_q[16:1];

	always_comb begin
		case (i_cfg.mix)
			MIX_OFF:  mix_d = sum_q;
			MIX_25:   mix_d = $signed(sum_q) - ($signed(sum_q) >>> 3) + ($signed(pre_w) >>> 2);
			MIX_50:   mix_d = $signed(sum_q) - ($signed(sum_q) >>> 2) + ($signed(pre_w) >>> 1);
			MIX_MONO: mix_d = ($signed(sum_q) >>> 1) + $signed(pre_w);
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			core_dly <= '{default: '0};
			lin_dly  <= '{default: '0};
			core_ok  <= '0;
			conv_q   <= '0;
			sum_q    <= '0;
			mix_q    <= '0;
			att_q    <= '0;
			o_sample <= '0;
		end else begin
			for (int i = 1; i < GLITCH_DLY; i++) begin
				core_dly[i] <= core_dly[i-1];
				lin_dly[i]  <= lin_dly[i-1];
			end
			core_dly[0] <= i_core;
			lin_dly[0]  <= i_linux;

			// Accept only a value seen on two cycles in a row
			if (core_dly[GLITCH_DLY-2] == core_dly[GLITCH_DLY-1])
				core_ok <= core_dly[GLITCH_DLY-2];

			conv_q <= conv_d;
			sum_q  <= conv_q + {lin_dly[GLITCH_DLY-1][15], lin_dly[GLITCH_DLY-1]};
			mix_q  <= mix_d;

			if (i_cfg.att[ATT_W-1])
				att_q <= '0;
			else
				att_q <= $signed(mix_q) >>> i_cfg.att[ATT_W-2:0];

			// Saturate when the two top bits disagree
			o_sample <= (att_q[16] ^ att_q[15]) ? {att_q[16], {15{~att_q[16]}}} : att_q[15:0];
		end
	end

	// Mute held over the last two stages forces silence
	a_mute_zero: assert property (
		@(posedge i_clk) disable iff (i_resetd)
		i_cfg.att[ATT_W-1] [*4] |-> o_sample == '0
	);

endmodule

`default_nettype wire

/* hdl/hps_cmd_regs.sv */
/*
  Host command port
  - two-stage capture of the host strobe and data word
  - strobe acknowledge and rising edge detect
  - command byte decoder with LED and volume registers
*/
`timescale 1ns/1ps
`default_nettype none

module hps_cmd_regs
	import sys_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_resetd,

	input  wire        i_io_uio,
	input  wire        i_io_clk,
	input  wire [15:0] i_io_din,
	output logic       o_io_ack,

	output att_t       o_att,
	output led_ctrl_t  o_led
);

	logic       io_clk_d1;
	logic       io_clk_d2;
	host_word_t io_din_d1;
	host_word_t io_din_d2;
	logic       strobe_rise;
	cmd_state_t state;
	logic [7:0] cmd_q;

	//////////////////////////////
	// Host strobe capture

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			io_clk_d1 <= 1'b0;
			io_clk_d2 <= 1'b0;
			o_io_ack  <= 1'b0;
		end else begin
			io_clk_d1 <= i_io_clk;
			io_clk_d2 <= io_clk_d1;
			// Third stage doubles as the acknowledge
			o_io_ack  <= io_clk_d2;
		end
	end

	// Data is stable while the strobe is high
	always_ff @(posedge i_clk) begin
		io_din_d1 <= i_io_din;
		io_din_d2 <= io_din_d1;
	end

	assign strobe_rise = io_clk_d2 & ~o_io_ack;

	//////////////////////////////
	// Command decoder

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			state <= CMD_IDLE;
			cmd_q <= '0;
			o_att <= '0;
			o_led <= '0;
		end else if (!i_io_uio) begin
			state <= CMD_IDLE;
		end else if (strobe_rise) begin
			case (state)
				CMD_IDLE: begin
					// First word after select carries the command byte
					cmd_q <= io_din_d2[7:0];
					state <= CMD_DATA;
				end
				CMD_DATA: begin
					case (cmd_q)
						CMD_LED: o_led <= led_ctrl_t'(io_din_d2);
						CMD_VOL: o_att <= att_t'(io_din_d2[ATT_W-1:0]);
						default: begin
							// Unknown command, data is dropped
						end
					endcase
				end
				default: state <= CMD_IDLE;
			endcase
		end
	end

	// Released select always parks the decoder
	a_idle_on_deselect: assert property (
		@(posedge i_clk) disable iff (i_resetd)
		!i_io_uio |=> state == CMD_IDLE
	);

endmodule

`default_nettype wire

/* hdl/panel_io.sv */
/*
  Front panel logic
  - user and OSD button synchronizers and debouncers
  - main board LED multiplexer, host override or core status
*/
`timescale 1ns/1ps
`default_nettype none

module panel_io
	import sys_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_resetd,
	input  wire [1:0]       i_btn_raw,
	input  wire core_leds_t i_core_leds,
	input  wire led_ctrl_t  i_led,
	output logic [1:0]      o_btn,
	output logic [7:0]      o_led
);

	logic [DEB_CNT_W-1:0] tick_cnt;
	logic                 tick;
	logic [1:0]           btn_meta;
	logic [1:0]           btn_sync;
	logic [DEB_LEN-1:0]   deb_sr [2];
	logic                 power_lit;
	logic                 disk_lit;
	logic [7:0]           led_def;

	//////////////////////////////
	// Button debounce

	assign tick = (tick_cnt == DEB_CNT_W'(DEB_TICK - 1));

	always_ff @(posedge i_clk) begin
		if (i_resetd) begin
			tick_cnt <= '0;
			btn_meta <= '0;
			btn_sync <= '0;
			deb_sr   <= '{default: '0};
			o_btn    <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			btn_meta <= i_btn_raw;
			btn_sync <= btn_meta;
			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					deb_sr[i] <= {deb_sr[i][DEB_LEN-2:0], btn_sync[i]};
					if (&deb_sr[i])
						o_btn[i] <= 1'b1;
					if (~|deb_sr[i])
						o_btn[i] <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////
	// Board LEDs

	assign power_lit = &i_core_leds.power;
	// Low disk bit alone lights when the high bit is clear
	assign disk_lit  = &i_core_leds.disk | (~i_core_leds.disk[1] & i_core_leds.disk[0]);
	assign led_def   = {3'b000, power_lit, 1'b0, disk_lit, 1'b0, i_core_leds.user};

	assign o_led = (i_led.overtake & i_led.state) | (~i_led.overtake & led_def);

endmodule

`default_nettype wire

/* hdl/sys_audio_top.sv */
/*
  Audio and host control top level
  - host command register block
  - left and right mixer channels with cross-mix exchange
  - button debounce and board LED logic
*/
`timescale 1ns/1ps
`default_nettype none

module sys_audio_top
	import sys_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_resetd,

	input  wire             i_io_uio,
	input  wire             i_io_clk,
	input  wire [15:0]      i_io_din,
	output logic            o_io_ack,

	input  wire sample_t    i_core_l,
	input  wire sample_t    i_core_r,
	input  wire sample_t    i_linux_l,
	input  wire sample_t    i_linux_r,
	input  wire mix_mode_t  i_mix,
	input  wire             i_is_signed,

	input  wire core_leds_t i_core_leds,
	input  wire [1:0]       i_btn_raw,

	output sample_t         o_audio_l,
	output sample_t         o_audio_r,
	output logic [1:0]      o_btn,
	output logic [7:0]      o_led
);

	att_t       att;
	led_ctrl_t  led_ctrl;
	audio_cfg_t aud_cfg;
	sample_t    pre_l;
	sample_t    pre_r;

	// Host volume joins the core's mix and sign settings
	assign aud_cfg = '{att: att, mix: i_mix, is_signed: i_is_signed};

	hps_cmd_regs regs0 (
		.i_clk    (i_clk),
		.i_resetd (i_resetd),
		.i_io_uio (i_io_uio),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.o_att    (att),
		.o_led    (led_ctrl)
	);

	aud_mix_chan mix_l (
		.i_clk    (i_clk),
		.i_resetd (i_resetd),
		.i_cfg    (aud_cfg),
		.i_core   (i_core_l),
		.i_linux  (i_linux_l),
		.i_pre_in (pre_r),
		.o_pre    (pre_l),
		.o_sample (o_audio_l)
	);

	aud_mix_chan mix_r (
		.i_clk    (i_clk),
		.i_resetd (i_resetd),
		.i_cfg    (aud_cfg),
		.i_core   (i_core_r),
		.i_linux  (i_linux_r),
		.i_pre_in (pre_l),
		.o_pre    (pre_r),
		.o_sample (o_audio_r)
	);

	panel_io panel0 (
		.i_clk       (i_clk),
		.i_resetd    (i_resetd),
		.i_btn_raw   (i_btn_raw),
		.i_core_leds (i_core_leds),
		.i_led       (led_ctrl),
		.o_btn       (o_btn),
		.o_led       (o_led)
	);

endmodule

`default_nettype wire

/* hdl/sys_pkg.sv */
/*
  Shared definitions for the host port, audio mixer and panel logic
  - sample, host word and attenuation widths
  - cross-mix mode and command decoder enums
  - audio configuration, LED control and core LED structs
  - host command codes and button debounce timing
*/
`default_nettype none

package sys_pkg;

	//////////////////////////////
	// Widths

	localparam int SAMPLE_W = 16;
	localparam int HOST_W   = 16;
	localparam int ATT_W    = 5;

	typedef logic [SAMPLE_W-1:0] sample_t;
	// One extra bit of headroom for the mixer sum
	typedef logic [SAMPLE_W:0]   wide_sample_t;
	typedef logic [HOST_W-1:0]   host_word_t;
	// Top bit mutes, low four bits are a right shift count
	typedef logic [ATT_W-1:0]    att_t;

	typedef enum logic [1:0] {
		MIX_OFF  = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

	typedef enum logic {
		CMD_IDLE = 1'b0,
		CMD_DATA = 1'b1
	} cmd_state_t;

	//////////////////////////////
	// Structs

	typedef struct packed {
		att_t      att;
		mix_mode_t mix;
		logic      is_signed;
	} audio_cfg_t;

	// Written whole by one host word, mask in the high byte
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_ctrl_t;

	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} core_leds_t;

	//////////////////////////////
	// Commands and timing

	localparam logic [7:0] CMD_LED = 8'h25;
	localparam logic [7:0] CMD_VOL = 8'h26;

	// Core sample delay line depth, sets the glitch filter latency
	localparam int GLITCH_DLY = 4;

	// Kept short for simulation, a board build would use about 100000
	localparam int DEB_TICK  = 16;
	localparam int DEB_CNT_W = $clog2(DEB_TICK);
	localparam int DEB_LEN   = 8;

endpackage

`default_nettype wire

/* testbench/tb_sys_audio_top.sv */
/*
  Directed testbench for the audio and host control top level
  - clock, reset and host command driver with acknowledge timeouts
  - reference model of the two-channel mixer and the board LED rule
  - reset, LED override, mixer, debounce and ignored write tests
*/
`timescale 1ns/1ps
`default_nettype none

module tb_sys_audio_top
	import sys_pkg::*;
();

	localparam int ACK_LIMIT = 16;
	localparam int BTN_LIMIT = DEB_TICK * (DEB_LEN + 2);

	logic       clk;
	logic       resetd;
	logic       io_uio;
	logic       io_clk;
	host_word_t io_din;
	logic       io_ack;
	sample_t    core_l;
	sample_t    core_r;
	sample_t    linux_l;
	sample_t    linux_r;
	mix_mode_t  mix;
	logic       is_signed;
	core_leds_t core_leds;
	logic [1:0] btn_raw;
	sample_t    audio_l;
	sample_t    audio_r;
	logic [1:0] btn;
	logic [7:0] led;

	// Testbench copies of the register contents
	att_t       att_sel;
	led_ctrl_t  led_sel;
	host_word_t data_q [$];
	int         errors;
	int         timeouts;

	sys_audio_top dut0 (
		.i_clk       (clk),
		.i_resetd    (resetd),
		.i_io_uio    (io_uio),
		.i_io_clk    (io_clk),
		.i_io_din    (io_din),
		.o_io_ack    (io_ack),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_linux_l   (linux_l),
		.i_linux_r   (linux_r),
		.i_mix       (mix),
		.i_is_signed (is_signed),
		.i_core_leds (core_leds),
		.i_btn_raw   (btn_raw),
		.o_audio_l   (audio_l),
		.o_audio_r   (audio_r),
		.o_btn       (btn),
		.o_led       (led)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////
	// Reference models

	function automatic wide_sample_t channel_sum(input sample_t core, input sample_t lin,
			input logic sgn);
		int c;
		// Unsigned core audio is halved with a zero top bit
		if (sgn)
			c = int'($signed(core));
		else
			c = int'(core) / 2;
		return wide_sample_t'(c + int'($signed(lin)));
	endfunction

	function automatic sample_t mix_model(input sample_t core_s, input sample_t lin_s,
			input sample_t core_o, input sample_t lin_o, input mix_mode_t mode,
			input logic sgn, input att_t att);
		wide_sample_t ws;
		wide_sample_t wo;
		int s;
		int pre_o;
		int v;
		ws = channel_sum(core_s, lin_s, sgn);
		wo = channel_sum(core_o, lin_o, sgn);
		s = int'($signed(ws));
		pre_o = int'($signed(wo)) >>> 1;
		case (mode)
			MIX_OFF: v = s;
			MIX_25:  v = s - (s >>> 3) + (pre_o >>> 2);
			MIX_50:  v = s - (s >>> 2) + (pre_o >>> 1);
			default: v = (s >>> 1) + pre_o;
		endcase
		if (att[4])
			v = 0;
		else
			v = v >>> att[3:0];
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return sample_t'(v);
	endfunction

	function automatic logic [7:0] default_leds(input core_leds_t c);
		logic pwr;
		logic dsk;
		pwr = (c.power == 2'b11);
		dsk = (c.disk == 2'b11) || (c.disk == 2'b01);
		return {3'b000, pwr, 1'b0, dsk, 1'b0, c.user};
	endfunction

	// Masked bits follow the override state, the rest the default pattern
	function automatic logic [7:0] expected_leds(input led_ctrl_t ctl, input core_leds_t c);
		logic [7:0] dflt;
		logic [7:0] res;
		dflt = default_leds(c);
		for (int b = 0; b < 8; b++) begin
			if (ctl.overtake[b])
				res[b] = ctl.state[b];
			else
				res[b] = dflt[b];
		end
		return res;
	endfunction

	//////////////////////////////
	// Compare tasks

	task automatic check_sample(input string what, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_led(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: LEDs %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_btn(input string what, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: buttons %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic compare_audio(input string what);
		check_sample({what, " left"}, audio_l,
			mix_model(core_l, linux_l, core_r, linux_r, mix, is_signed, att_sel));
		check_sample({what, " right"}, audio_r,
			mix_model(core_r, linux_r, core_l, linux_l, mix, is_signed, att_sel));
	endtask

	//////////////////////////////
	// Host port and stimulus

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (io_ack !== level && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (io_ack !== level) begin
			$display("Timeout at %0t: host acknowledge never reached %0b", $time, level);
			timeouts++;
		end
	endtask

	task automatic send_word(input host_word_t word);
		@(negedge clk);
		io_din = word;
		io_clk = 1'b1;
		wait_ack(1'b1);
		io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	// Command byte first and then every queued data word
	task automatic host_cmd(input logic [7:0] cmd);
		@(negedge clk);
		io_uio = 1'b1;
		send_word({8'h00, cmd});
		while (data_q.size() > 0)
			send_word(data_q.pop_front());
		@(negedge clk);
		io_uio = 1'b0;
	endtask

	task automatic set_volume(input att_t att);
		data_q = {{11'd0, att}};
		host_cmd(CMD_VOL);
		att_sel = att;
	endtask

	task automatic wait_btn(input logic [1:0] exp);
		int n;
		n = 0;
		while (btn !== exp && n < BTN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (btn !== exp) begin
			$display("Timeout at %0t: debounced buttons never reached %b", $time, exp);
			timeouts++;
		end
	endtask

	// Held samples settle through the 10-stage path well inside 12 cycles
	task automatic play_samples(input sample_t cl, input sample_t cr, input sample_t ll,
			input sample_t lr);
		@(negedge clk);
		core_l = cl;
		core_r = cr;
		linux_l = ll;
		linux_r = lr;
		repeat (12) @(negedge clk);
		compare_audio($sformatf("mix=%0d signed=%0b att=%h", mix, is_signed, att_sel));
	endtask

	//////////////////////////////
	// Tests

	task automatic after_reset();
		for (int k = 0; k < 32; k++) begin
			@(negedge clk);
			core_leds = 5'(k);
			@(negedge clk);
			check_led("default pattern", led, default_leds(core_leds));
		end
		check_sample("reset left", audio_l, 16'h0000);
		check_sample("reset right", audio_r, 16'h0000);
		check_btn("reset buttons", btn, 2'b00);
	endtask

	task automatic led_override();
		host_word_t w;
		for (int i = 0; i < 6; i++) begin
			w = host_word_t'($urandom);
			// Two data words where only the later one stays
			data_q = {host_word_t'($urandom), w};
			host_cmd(CMD_LED);
			led_sel = w;
			for (int k = 0; k < 4; k++) begin
				@(negedge clk);
				core_leds = 5'($urandom_range(31, 0));
				@(negedge clk);
				check_led("override", led, expected_leds(led_sel, core_leds));
			end
		end
	endtask

	task automatic plain_mix();
		@(negedge clk);
		mix = MIX_OFF;
		for (int i = 0; i < 8; i++) begin
			is_signed = i[0];
			play_samples(sample_t'($urandom), sample_t'($urandom),
				sample_t'($urandom), sample_t'($urandom));
		end
	endtask

	task automatic mix_modes();
		att_t att_list [5];
		att_list = '{5'd0, 5'd1, 5'd3, 5'd15, 5'h10};
		for (int m = 0; m < 4; m++) begin
			for (int a = 0; a < 5; a++) begin
				set_volume(att_list[a]);
				@(negedge clk);
				mix = mix_mode_t'(m);
				is_signed = 1'b1;
				play_samples(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
				play_samples(16'h8000, 16'h8000, 16'h8000, 16'h8000);
				play_samples(16'h7FFF, 16'h8000, 16'h4000, 16'hC000);
				play_samples(sample_t'($urandom), sample_t'($urandom),
					sample_t'($urandom), sample_t'($urandom));
				is_signed = 1'b0;
				play_samples(16'hFFFF, 16'h0000, 16'h7FFF, 16'h8000);
				play_samples(sample_t'($urandom), sample_t'($urandom),
					sample_t'($urandom), sample_t'($urandom));
			end
		end
	endtask

	task automatic button_debounce();
		logic [1:0] seen;
		seen = 2'b00;
		// One sample period high is caught by a single tick only
		@(negedge clk);
		btn_raw = 2'b11;
		repeat (DEB_TICK) @(negedge clk);
		btn_raw = 2'b00;
		repeat (BTN_LIMIT) begin
			@(negedge clk);
			seen = seen | btn;
		end
		check_btn("single tick pulse", seen, 2'b00);
		btn_raw = 2'b11;
		wait_btn(2'b11);
		check_btn("held high", btn, 2'b11);
		btn_raw = 2'b00;
		wait_btn(2'b00);
		check_btn("released", btn, 2'b00);
		btn_raw = 2'b10;
		wait_btn(2'b10);
		check_btn("osd only", btn, 2'b10);
		btn_raw = 2'b00;
		wait_btn(2'b00);
	endtask

	task automatic ignored_writes();
		set_volume(5'd2);
		data_q = {16'hA55A};
		host_cmd(CMD_LED);
		led_sel = 16'hA55A;
		@(negedge clk);
		mix = MIX_50;
		is_signed = 1'b1;
		// All core LED requests on so a stray LED write shows
		core_leds = 5'b11111;
		play_samples(16'h1234, 16'hE000, 16'h0F00, 16'h8100);

		// Mute and all-on words under an unknown command
		data_q = {16'h0010, 16'h00FF};
		host_cmd(8'h31);
		repeat (12) @(negedge clk);
		compare_audio("unknown command");
		check_led("unknown command", led, expected_leds(led_sel, core_leds));

		// Data strobed after select is released
		@(negedge clk);
		io_uio = 1'b1;
		send_word({8'h00, CMD_VOL});
		@(negedge clk);
		io_uio = 1'b0;
		send_word(16'h0010);
		@(negedge clk);
		io_uio = 1'b1;
		send_word({8'h00, CMD_LED});
		@(negedge clk);
		io_uio = 1'b0;
		send_word(16'hFF00);
		repeat (12) @(negedge clk);
		compare_audio("select dropped");
		check_led("select dropped", led, expected_leds(led_sel, core_leds));
	endtask

	//////////////////////////////
	// Main sequence

	initial begin
		resetd = 1'b1;
		io_uio = 1'b0;
		io_clk = 1'b0;
		io_din = '0;
		core_l = '0;
		core_r = '0;
		linux_l = '0;
		linux_r = '0;
		mix = MIX_OFF;
		is_signed = 1'b0;
		core_leds = '0;
		btn_raw = 2'b00;
		att_sel = '0;
		led_sel = '0;
		errors = 0;
		timeouts = 0;
		void'($urandom(32'hf4417b1a));

		repeat (16) @(negedge clk);
		resetd = 1'b0;

		after_reset();
		led_override();
		plain_mix();
		mix_modes();
		button_debounce();
		ignored_writes();

		$display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire
